// File: verilog/chart_pkg.sv
package chart_pkg;

    // Note word
    // [8] octave down, [7] octave up, [6:0] one-hot pitch C..B
    typedef logic [8:0] note_t;

    // Position inside a chart or a take
    typedef logic [5:0] note_idx_t;

    typedef logic [13:0] score_t;

    // Depth of a chart and of the take buffer
    localparam int CHART_LEN = 32;

    // Timing, scaled down for simulation
    localparam int COUNT_STEP_CYCLES = 8;
    localparam int NOTE_CYCLES = 12;
    localparam int SCAN_CYCLES = 4;

    // Points per judged scan
    localparam score_t HIT_ON_TIME = 14'd5;
    localparam score_t HIT_LATE_1 = 14'd3;
    localparam score_t HIT_LATE_2 = 14'd2;
    localparam score_t HIT_AUTO = 14'd4;

    // Best case for one scan, kept as the reference score
    localparam score_t HIT_MAX = 14'd5;

    // Page flow
    typedef enum logic [1:0] {
        COUNTDOWN,
        PLAYING,
        FINISHED
    } play_state_t;

endpackage

// File: verilog/panel_pkg.sv
package panel_pkg;

    // Arrow key codes
    typedef logic [1:0] arrow_t;

    localparam arrow_t ARROW_NONE = 2'd0;
    localparam arrow_t ARROW_LEFT = 2'd1;   // exit
    localparam arrow_t ARROW_RIGHT = 2'd2;  // save

    // User panel as sampled on prog_clk
    typedef struct packed {
        logic [6:0] note_keys;
        logic       oct_up;
        logic       oct_down;
        arrow_t     arrow;
    } panel_in_t;

    // Bit 0 is the octave LED, bits 7..1 are C..B
    typedef logic [7:0] led_t;

    // Eight ASCII characters, leftmost in the top byte
    typedef logic [63:0] seg_text_t;

    localparam seg_text_t SEG_BLANK = "        ";

    // One beat of the save stream
    typedef logic [15:0] save_payload_t;

    typedef struct packed {
        logic                 is_summary;
        chart_pkg::note_idx_t index;
        save_payload_t        payload;
    } save_beat_t;

    // Beats the store can take before returning credit
    localparam int SAVE_CREDITS = 4;

endpackage

// File: verilog/play_sequencer.sv
`timescale 1ns/100ps

module play_sequencer (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  panel_pkg::panel_in_t   panel,
    input  logic                   auto_play,
    input  chart_pkg::note_idx_t   chart_len,
    input  chart_pkg::note_t       chart_note,
    output chart_pkg::play_state_t state,
    output logic [1:0]             countdown_digit,
    output chart_pkg::note_idx_t   note_idx,
    output logic                   note_tick,
    output logic                   scan_tick,
    output chart_pkg::note_t       played_note,
    output logic                   exit_req
);
    import chart_pkg::*;
    import panel_pkg::*;

    localparam int STEP_W = $clog2(COUNT_STEP_CYCLES);
    localparam int NOTE_W = $clog2(NOTE_CYCLES);
    localparam int SCAN_W = $clog2(SCAN_CYCLES);

    logic [STEP_W-1:0] step_cnt;
    logic [NOTE_W-1:0] note_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic              step_done;
    note_t             user_note;

    assign step_done = step_cnt == STEP_W'(COUNT_STEP_CYCLES - 1);
    assign note_tick = (state == PLAYING) && (note_cnt == NOTE_W'(NOTE_CYCLES - 1));
    assign scan_tick = (state == PLAYING) && (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));
    assign user_note = {panel.oct_down, panel.oct_up, panel.note_keys};

    // Countdown 3..0, then play until the chart runs out
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= COUNTDOWN;
            countdown_digit <= 2'd3;
            step_cnt <= '0;
            note_idx <= '0;
        end else begin
            case (state)
                COUNTDOWN: begin
                    step_cnt <= step_done ? '0 : step_cnt + 1'b1;
                    if (step_done) begin
                        if (countdown_digit != 2'd0) begin
                            countdown_digit <= countdown_digit - 1'b1;
                        end else if (chart_len == '0) begin
                            state <= FINISHED;
                        end else begin
                            state <= PLAYING;
                        end
                    end
                end
                PLAYING: begin
                    if (note_tick) begin
                        note_idx <= note_idx + 1'b1;
                        if (note_idx + 1'b1 == chart_len) begin
                            state <= FINISHED;
                        end
                    end
                end
                default: begin
                    state <= FINISHED;
                end
            endcase
        end
    end

    // Tick enables, restarted on entry to PLAYING
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_cnt <= '0;
            scan_cnt <= '0;
        end else if (state != PLAYING) begin
            note_cnt <= '0;
            scan_cnt <= '0;
        end else begin
            note_cnt <= note_tick ? '0 : note_cnt + 1'b1;
            scan_cnt <= scan_tick ? '0 : scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            played_note <= '0;
        end else if (note_tick) begin
            played_note <= auto_play ? chart_note : user_note;
        end
    end

    // Exit request is sticky until reset
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            exit_req <= 1'b0;
        end else if (state != COUNTDOWN && panel.arrow == ARROW_LEFT) begin
            exit_req <= 1'b1;
        end
    end

    // Chart address stays inside the chart the store reported
    note_idx_in_chart: assert property (@(posedge prog_clk) disable iff (rst)
        note_idx <= chart_len)
        else $error("note_idx %0d beyond chart_len %0d", note_idx, chart_len);

endmodule

// File: verilog/score_judge.sv
`timescale 1ns/100ps

module score_judge (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  chart_pkg::play_state_t state,
    input  logic                   scan_tick,
    input  logic                   auto_play,
    input  panel_pkg::panel_in_t   panel,
    input  chart_pkg::note_t       chart_note,
    output chart_pkg::score_t      score,
    output chart_pkg::score_t      max_score
);
    import chart_pkg::*;

    note_t  cur_keys;
    note_t  hist_near;
    note_t  hist_far;
    logic   key_down;
    logic   judge_en;
    score_t hit_points;

    assign cur_keys = {panel.oct_down, panel.oct_up, panel.note_keys};
    assign key_down = |panel.note_keys;

    // Rests in the chart are not judged
    assign judge_en = scan_tick && (state == PLAYING) && (|chart_note[6:0]);

    // Credit for this scan, best match first
    always_comb begin
        if (auto_play) begin
            hit_points = HIT_AUTO;
        end else if (!key_down) begin
            hit_points = '0;
        end else if (cur_keys == chart_note) begin
            hit_points = HIT_ON_TIME;
        end else if (hist_near == chart_note) begin
            hit_points = HIT_LATE_1;
        end else if (hist_far == chart_note) begin
            hit_points = HIT_LATE_2;
        end else begin
            hit_points = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            max_score <= '0;
            hist_near <= '0;
            hist_far <= '0;
        end else if (judge_en) begin
            max_score <= max_score + HIT_MAX;
            score <= score + hit_points;
            // History keeps only samples with a key down
            if (!auto_play && key_down) begin
                hist_near <= cur_keys;
                hist_far <= hist_near;
            end
        end
    end

endmodule

// File: verilog/note_indicator.sv
`timescale 1ns/100ps

module note_indicator (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  chart_pkg::play_state_t state,
    input  chart_pkg::note_t       chart_note,
    output panel_pkg::led_t        led,
    output panel_pkg::seg_text_t   seg
);
    import chart_pkg::*;
    import panel_pkg::*;

    logic [6:0] pitch;
    logic [1:0] octave;
    logic       note_ok;
    logic [2:0] pitch_num;
    logic [7:0] letter_ch;
    logic [7:0] octave_ch;
    logic [7:0] digit_ch;
    led_t       led_next;
    seg_text_t  seg_next;

    assign pitch = chart_note[6:0];
    assign octave = chart_note[8:7];

    // Exactly one pitch, never both octave shifts
    assign note_ok = $onehot(pitch) && (octave != 2'b11);

    always_comb begin
        pitch_num = '0;
        for (int i = 0; i < 7; i++) begin
            if (pitch[i]) begin
                pitch_num = 3'(i);
            end
        end
    end

    always_comb begin
        case (pitch_num)
            3'd0: letter_ch = "c";
            3'd1: letter_ch = "d";
            3'd2: letter_ch = "e";
            3'd3: letter_ch = "f";
            3'd4: letter_ch = "g";
            3'd5: letter_ch = "a";
            default: letter_ch = "b";
        endcase
        case (octave)
            2'b01: octave_ch = "u";
            2'b10: octave_ch = "d";
            default: octave_ch = " ";
        endcase
    end

    // Scale degree 1..7
    assign digit_ch = 8'h31 + 8'(pitch_num);

    // C sits on the leftmost LED
    always_comb begin
        led_next = '0;
        if (note_ok) begin
            led_next[0] = |octave;
            for (int i = 0; i < 7; i++) begin
                led_next[7 - i] = pitch[i];
            end
        end
    end

    assign seg_next = note_ok ? {letter_ch, " ", octave_ch, " ", digit_ch, "   "} : SEG_BLANK;

    // Outside PLAYING the last note stays on show
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= SEG_BLANK;
        end else if (state == PLAYING) begin
            led <= led_next;
            seg <= seg_next;
        end
    end

endmodule

// File: verilog/take_recorder.sv
`timescale 1ns/100ps

module take_recorder (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  chart_pkg::play_state_t state,
    input  chart_pkg::note_idx_t   note_idx,
    input  logic                   note_tick,
    input  panel_pkg::panel_in_t   panel,
    input  chart_pkg::score_t      score,
    input  chart_pkg::score_t      max_score,
    input  logic                   credit_return,
    output logic                   save_valid,
    output panel_pkg::save_beat_t  save_beat
);
    import chart_pkg::*;
    import panel_pkg::*;

    localparam int ADDR_W = $clog2(CHART_LEN);
    localparam int CRED_W = $clog2(SAVE_CREDITS + 1);

    note_t             take_mem [CHART_LEN];
    logic              right_prev;
    logic              save_req;
    logic              streaming;
    note_idx_t         save_len;
    note_idx_t         beat_idx;
    logic [CRED_W-1:0] credits;
    logic              send;
    logic              last_beat;
    save_beat_t        beat_next;

    // A fresh right-arrow press starts a save when idle
    assign save_req = (panel.arrow == ARROW_RIGHT) && !right_prev
                      && (state != COUNTDOWN) && !streaming;
    assign send = streaming && (credits != '0);

    // Summary follows the last recorded note
    assign last_beat = beat_idx == save_len;

    always_ff @(posedge prog_clk) begin
        if (note_tick && state == PLAYING) begin
            take_mem[note_idx[ADDR_W-1:0]] <= {panel.oct_down, panel.oct_up, panel.note_keys};
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            right_prev <= 1'b0;
            streaming <= 1'b0;
            save_len <= '0;
            beat_idx <= '0;
        end else begin
            right_prev <= panel.arrow == ARROW_RIGHT;
            if (save_req) begin
                streaming <= 1'b1;
                save_len <= note_idx;
                beat_idx <= '0;
            end else if (send) begin
                if (last_beat) begin
                    streaming <= 1'b0;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end
        end
    end

    // One credit per beat out, one per pulse back
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            credits <= CRED_W'(SAVE_CREDITS);
        end else begin
            credits <= credits - CRED_W'(send) + CRED_W'(credit_return);
        end
    end

    always_comb begin
        beat_next.is_summary = last_beat;
        beat_next.index = beat_idx;
        if (last_beat) begin
            beat_next.payload = save_payload_t'(score);
        end else begin
            beat_next.payload = save_payload_t'(take_mem[beat_idx[ADDR_W-1:0]]);
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            save_valid <= 1'b0;
        end else begin
            save_valid <= send;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (send) begin
            save_beat <= beat_next;
        end
    end

    credit_bound: assert property (@(posedge prog_clk) disable iff (rst)
        credits <= CRED_W'(SAVE_CREDITS))
        else $error("credit count %0d above limit", credits);

    // Store returns credit only for beats it was sent
    credit_return_bound: assert property (@(posedge prog_clk) disable iff (rst)
        credit_return && !send |-> credits < CRED_W'(SAVE_CREDITS))
        else $error("credit returned with all credits held");

    // The summary never claims more than the judge allowed
    summary_score_bound: assert property (@(posedge prog_clk) disable iff (rst)
        score <= max_score)
        else $error("score %0d above max_score %0d", score, max_score);

endmodule

// File: verilog/play_top.sv
`timescale 1ns/100ps

module play_top (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  panel_pkg::panel_in_t   panel,
    input  logic                   auto_play,
    input  chart_pkg::note_idx_t   chart_len,
    input  chart_pkg::note_t       chart_note,
    output chart_pkg::note_idx_t   chart_addr,
    output logic [1:0]             countdown_digit,
    output chart_pkg::play_state_t state,
    output chart_pkg::note_t       played_note,
    output chart_pkg::score_t      score,
    output chart_pkg::score_t      max_score,
    output panel_pkg::led_t        led,
    output panel_pkg::seg_text_t   seg,
    output logic                   exit_req,
    output logic                   save_valid,
    output panel_pkg::save_beat_t  save_beat,
    input  logic                   credit_return
);
    import chart_pkg::*;

    note_idx_t note_idx;
    logic      note_tick;
    logic      scan_tick;

    // Chart store is read at the current note
    assign chart_addr = note_idx;

    play_sequencer u_sequencer (
        .prog_clk        (prog_clk),
        .rst             (rst),
        .panel           (panel),
        .auto_play       (auto_play),
        .chart_len       (chart_len),
        .chart_note      (chart_note),
        .state           (state),
        .countdown_digit (countdown_digit),
        .note_idx        (note_idx),
        .note_tick       (note_tick),
        .scan_tick       (scan_tick),
        .played_note     (played_note),
        .exit_req        (exit_req)
    );

    score_judge u_judge (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .state      (state),
        .scan_tick  (scan_tick),
        .auto_play  (auto_play),
        .panel      (panel),
        .chart_note (chart_note),
        .score      (score),
        .max_score  (max_score)
    );

    note_indicator u_indicator (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .state      (state),
        .chart_note (chart_note),
        .led        (led),
        .seg        (seg)
    );

    take_recorder u_recorder (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .state         (state),
        .note_idx      (note_idx),
        .note_tick     (note_tick),
        .panel         (panel),
        .score         (score),
        .max_score     (max_score),
        .credit_return (credit_return),
        .save_valid    (save_valid),
        .save_beat     (save_beat)
    );

endmodule

// File: dv/play_tb.sv
`timescale 1ns/100ps

module play_tb;
    import chart_pkg::*;
    import panel_pkg::*;

    localparam int CLK_HALF = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RUNS = 2;
    localparam int NUM_STEPS = 6;
    localparam int RUN_WORDS = 4;
    localparam int STEP_BASE = NUM_RUNS * RUN_WORDS;
    localparam int STIM_WORDS = STEP_BASE + 2 * NUM_STEPS;
    localparam int MIN_DELAY = 3;
    localparam int MAX_DELAY = 8;
    localparam logic [31:0] RAND_SEED = 32'h1f30_c30c;
    localparam logic [55:0] PITCH_LETTERS = "cdefgab";

    logic        prog_clk = 1'b0;
    logic        rst;
    panel_in_t   panel;
    note_t       panel_keys;
    arrow_t      panel_arrow;
    logic        auto_play;
    note_idx_t   chart_len;
    note_t       chart_note;
    note_idx_t   chart_addr;
    logic [1:0]  countdown_digit;
    play_state_t state;
    note_t       played_note;
    score_t      score;
    score_t      max_score;
    led_t        led;
    seg_text_t   seg;
    logic        exit_req;
    logic        save_valid;
    save_beat_t  save_beat;
    logic        credit_return;

    logic [15:0] stim [STIM_WORDS];
    note_t       chart_mem [CHART_LEN];
    note_t       keys_mem [CHART_LEN];
    score_t      exp_score;
    score_t      exp_max;
    int          run_idx;
    int          run_len;
    int          checks = 0;
    int          errors = 0;
    int          watchdog_cycles = 0;

    // Monitor state updated once per falling edge
    play_state_t prev_state;
    note_idx_t   prev_addr;
    int          play_cycles;
    int          steps_seen;
    int          beat_count;
    logic        save_done;
    int          in_flight = 0;
    int          peak_in_flight;
    int          credit_wait [$];

    assign panel = {panel_keys[6:0], panel_keys[7], panel_keys[8], panel_arrow};
    assign chart_note = chart_mem[chart_addr[4:0]];

    play_top UUT (
        .prog_clk        (prog_clk),
        .rst             (rst),
        .panel           (panel),
        .auto_play       (auto_play),
        .chart_len       (chart_len),
        .chart_note      (chart_note),
        .chart_addr      (chart_addr),
        .countdown_digit (countdown_digit),
        .state           (state),
        .played_note     (played_note),
        .score           (score),
        .max_score       (max_score),
        .led             (led),
        .seg             (seg),
        .exit_req        (exit_req),
        .save_valid      (save_valid),
        .save_beat       (save_beat),
        .credit_return   (credit_return)
    );

    initial begin
        forever #CLK_HALF prog_clk = ~prog_clk;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: got %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("run %0d %s: ok", run_idx, name);
        end else begin
            $display("run %0d %s: %0d errors", run_idx, name, errors - err_mark);
        end
    endtask

    // Exactly one pitch and at most one octave shift
    function automatic logic note_valid(input note_t n);
        return ($countones(n[6:0]) == 1) && (n[8:7] != 2'b11);
    endfunction

    function automatic led_t expected_led(input note_t n);
        led_t result;
        result = '0;
        if (note_valid(n)) begin
            for (int i = 0; i < 7; i++) begin
                result[7 - i] = n[i];
            end
            result[0] = n[7] | n[8];
        end
        return result;
    endfunction

    function automatic seg_text_t expected_seg(input note_t n);
        int         pos;
        logic [7:0] oct_ch;
        seg_text_t  result;
        pos = 0;
        for (int i = 0; i < 7; i++) begin
            if (n[i]) begin
                pos = i;
            end
        end
        oct_ch = n[7] ? "u" : (n[8] ? "d" : " ");
        if (note_valid(n)) begin
            result = {PITCH_LETTERS[(6 - pos) * 8 +: 8], " ", oct_ch, " ",
                      8'h31 + 8'(pos), "   "};
        end else begin
            result = SEG_BLANK;
        end
        return result;
    endfunction

    // Judging rule over the scans of each note step with keys held per step
    task automatic model_score(input logic auto_mode, input int len,
                               output score_t model_s, output score_t model_m);
        note_t near_keys;
        note_t far_keys;
        note_t keys;
        note_t target;
        near_keys = '0;
        far_keys = '0;
        model_s = '0;
        model_m = '0;
        for (int k = 0; k < len; k++) begin
            target = chart_mem[k];
            keys = keys_mem[k];
            for (int s = 0; s < NOTE_CYCLES / SCAN_CYCLES; s++) begin
                if (target[6:0] != 7'd0) begin
                    model_m = model_m + HIT_MAX;
                    if (auto_mode) begin
                        model_s = model_s + HIT_AUTO;
                    end else if (keys[6:0] != 7'd0) begin
                        if (keys == target) begin
                            model_s = model_s + HIT_ON_TIME;
                        end else if (near_keys == target) begin
                            model_s = model_s + HIT_LATE_1;
                        end else if (far_keys == target) begin
                            model_s = model_s + HIT_LATE_2;
                        end
                        far_keys = near_keys;
                        near_keys = keys;
                    end
                end
            end
        end
    endtask

    function automatic int cycle_budget(input int len);
        return (len + 8) * NOTE_CYCLES + (len + 1) * (MAX_DELAY + 4)
               + SAVE_CREDITS * (MAX_DELAY + 2);
    endfunction

    task automatic load_run(input int r);
        auto_play = stim[r * RUN_WORDS][0];
        chart_len = stim[r * RUN_WORDS + 1][5:0];
        exp_score = stim[r * RUN_WORDS + 2][13:0];
        exp_max = stim[r * RUN_WORDS + 3][13:0];
        run_len = int'(chart_len);
        for (int k = 0; k < CHART_LEN; k++) begin
            chart_mem[k] = '0;
            keys_mem[k] = '0;
            if (k < NUM_STEPS) begin
                keys_mem[k] = stim[STEP_BASE + 2 * k + 1][8:0];
                if (k < run_len) begin
                    chart_mem[k] = stim[STEP_BASE + 2 * k][8:0];
                end
            end
        end
    endtask

    // One clock cycle ending on the falling edge where outputs are stable
    task automatic step_cycle();
        logic  is_sum;
        note_t shown;
        @(negedge prog_clk);

        // Store side of the save stream
        credit_return = 1'b0;
        if (credit_wait.size() > 0) begin
            if (credit_wait[0] == 0) begin
                credit_return = 1'b1;
                void'(credit_wait.pop_front());
                in_flight--;
            end else begin
                credit_wait[0] = credit_wait[0] - 1;
            end
        end
        if (save_valid) begin
            in_flight++;
            if (in_flight > peak_in_flight) begin
                peak_in_flight = in_flight;
            end
            if (in_flight > SAVE_CREDITS) begin
                report_error("more save beats in flight than credits");
            end
            credit_wait.push_back(int'($urandom_range(MAX_DELAY, MIN_DELAY)));
            if (save_done) begin
                report_error("save beat arrived after the summary beat");
            end else begin
                is_sum = beat_count == run_len;
                check_value("save_beat.index", 64'(save_beat.index), 64'(beat_count));
                check_value("save_beat.is_summary", 64'(save_beat.is_summary), 64'(is_sum));
                check_value("save_beat.payload", 64'(save_beat.payload),
                            is_sum ? 64'(exp_score) : 64'(keys_mem[beat_count]));
                beat_count++;
                save_done = is_sum;
            end
        end

        // Display lags the chart address by one cycle
        if (prev_state == PLAYING) begin
            play_cycles++;
            shown = chart_mem[prev_addr[4:0]];
            check_value("chart_addr", 64'(chart_addr), 64'(play_cycles / NOTE_CYCLES));
            check_value("led", 64'(led), 64'(expected_led(shown)));
            check_value("seg", seg, expected_seg(shown));
            if (chart_addr != prev_addr) begin
                check_value("played_note", 64'(played_note),
                            64'(auto_play ? shown : keys_mem[prev_addr[4:0]]));
                steps_seen++;
            end
        end
        prev_state = state;
        prev_addr = chart_addr;
        panel_keys = keys_mem[chart_addr[4:0]];
    endtask

    task automatic run_play(input int r);
        int     err_mark;
        int     waited;
        score_t model_s;
        score_t model_m;
        run_idx = r;
        rst = 1'b1;
        load_run(r);
        repeat (RESET_CYCLES) begin
            step_cycle();
        end
        rst = 1'b0;

        err_mark = errors;
        for (int n = 0; n < 4 * COUNT_STEP_CYCLES; n++) begin
            check_value("countdown_digit", 64'(countdown_digit),
                        64'(3 - n / COUNT_STEP_CYCLES));
            check_value("state", 64'(state), 64'(COUNTDOWN));
            check_value("save_valid", 64'(save_valid), 64'd0);
            check_value("exit_req", 64'(exit_req), 64'd0);
            check_value("led", 64'(led), 64'd0);
            check_value("seg", seg, SEG_BLANK);
            step_cycle();
        end
        check_value("state", 64'(state), 64'(PLAYING));
        finish_test("countdown", err_mark);

        err_mark = errors;
        play_cycles = 0;
        steps_seen = 0;
        waited = 0;
        while (state != FINISHED && waited < (run_len + 1) * NOTE_CYCLES) begin
            check_value("save_valid", 64'(save_valid), 64'd0);
            check_value("exit_req", 64'(exit_req), 64'd0);
            step_cycle();
            waited++;
        end
        if (state != FINISHED) begin
            report_error("timed out waiting for the chart to finish");
        end
        if (steps_seen != run_len) begin
            report_error("number of note steps differs from the chart length");
        end
        finish_test("playback", err_mark);

        err_mark = errors;
        model_score(auto_play, run_len, model_s, model_m);
        if (model_s != exp_score || model_m != exp_max) begin
            report_error("data file scores disagree with the judging rule");
        end
        check_value("score", 64'(score), 64'(exp_score));
        check_value("max_score", 64'(max_score), 64'(exp_max));
        finish_test("scoring", err_mark);

        err_mark = errors;
        beat_count = 0;
        save_done = 1'b0;
        peak_in_flight = 0;
        panel_arrow = ARROW_RIGHT;
        step_cycle();
        panel_arrow = ARROW_NONE;
        waited = 0;
        while (!save_done && waited < (run_len + 1) * (MAX_DELAY + 4)) begin
            step_cycle();
            waited++;
        end
        if (!save_done) begin
            report_error("timed out waiting for the summary beat");
        end
        waited = 0;
        while (in_flight != 0 && waited < SAVE_CREDITS * (MAX_DELAY + 2)) begin
            step_cycle();
            waited++;
        end
        if (in_flight != 0) begin
            report_error("credits were not all returned after the save");
        end
        if (peak_in_flight != SAVE_CREDITS) begin
            report_error("save stream never used all of its credits");
        end
        finish_test("save", err_mark);

        err_mark = errors;
        check_value("exit_req", 64'(exit_req), 64'd0);
        panel_arrow = ARROW_LEFT;
        step_cycle();
        panel_arrow = ARROW_NONE;
        for (int n = 0; n < 8; n++) begin
            step_cycle();
            check_value("exit_req", 64'(exit_req), 64'd1);
        end
        finish_test("exit", err_mark);
    endtask

    initial begin
        rst = 1'b1;
        panel_keys = '0;
        panel_arrow = ARROW_NONE;
        auto_play = 1'b0;
        chart_len = '0;
        credit_return = 1'b0;
        prev_state = COUNTDOWN;
        prev_addr = '0;
        play_cycles = 0;
        for (int k = 0; k < CHART_LEN; k++) begin
            chart_mem[k] = '0;
            keys_mem[k] = '0;
        end
        void'($urandom(RAND_SEED));
        $readmemh("dv/play_input.txt", stim);
        for (int r = 0; r < NUM_RUNS; r++) begin
            watchdog_cycles = watchdog_cycles + cycle_budget(int'(stim[r * RUN_WORDS + 1][5:0]));
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            run_play(r);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Budget is known once the data file has been read at time zero
    initial begin
        #1;
        repeat (watchdog_cycles) begin
            @(posedge prog_clk);
        end
        $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: compile.f
verilog/chart_pkg.sv
verilog/panel_pkg.sv
verilog/play_sequencer.sv
verilog/score_judge.sv
verilog/note_indicator.sv
verilog/take_recorder.sv
verilog/play_top.sv
dv/play_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the play page testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module play_tb -o play_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/play_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

exit 0

// File: dv/play_input.txt
// Run lines: auto_play chart_len expected_score expected_max_score
// Step lines: chart_note user_keys, one line per note step
0 6 32 4b
1 5 30 3c
001 001
084 084
000 000
010 120
120 040
040 040
